/* heap_config.svh */
//--------------------------------------------------------------------
// Heap configuration
// Array count, array length, element width and the credit counts
//--------------------------------------------------------------------
`ifndef HEAP_CONFIG_SVH
`define HEAP_CONFIG_SVH

// Heap dimensions
`define HEAP_ARRAY_BITS 2    // Four arrays
`define HEAP_INDEX_BITS 2    // Four elements per array
`define HEAP_DATA_BITS 12    // Element width

// Flow control
`define HEAP_CMD_DEPTH 4     // Queue entries, also initial host credits
`define HEAP_RSP_CREDITS 2   // Response credits after reset

`endif

/* heapPkg.sv */
//--------------------------------------------------------------------
// Heap package
// Opcodes, error codes, controller states and word types
//--------------------------------------------------------------------
`default_nettype none

`include "heap_config.svh"

package heapPkg;

  typedef enum logic [3:0] {
    opReset,    // Free every array
    opAlloc,
    opFree,
    opWrite,    // Extends size when past the end
    opRead,
    opSize,
    opPush,
    opPop,
    opAdd       // Returns the new value
  } heapOp;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,
    errOutOfBounds,
    errFull,
    errEmpty,
    errNoMemory
  } heapError;

  typedef enum logic [1:0] {
    stIdle,
    stCheck,
    stExecute,
    stRespond
  } ctrlState;

  typedef logic [`HEAP_ARRAY_BITS-1:0] arrayId;
  typedef logic [`HEAP_INDEX_BITS-1:0] elemIndex;
  typedef logic [`HEAP_INDEX_BITS:0]   arraySize;   // One extra bit for a full array
  typedef logic [`HEAP_DATA_BITS-1:0]  dataWord;

endpackage

`default_nettype wire

/* heapCommandQueue.sv */
//--------------------------------------------------------------------
// Command queue
// Circular FIFO of host commands, one credit returned per dequeue
//--------------------------------------------------------------------
`default_nettype none

`include "heap_config.svh"

module heapCommandQueue (
  input  logic              clock,
  input  logic              resetN,
  input  logic              cmdValid,
  input  heapPkg::heapOp    cmdOp,
  input  heapPkg::arrayId   cmdArray,
  input  heapPkg::elemIndex cmdIndex,
  input  heapPkg::dataWord  cmdData,
  input  logic              qPop,
  output logic              qValid,
  output heapPkg::heapOp    qOp,
  output heapPkg::arrayId   qArray,
  output heapPkg::elemIndex qIndex,
  output heapPkg::dataWord  qData,
  output logic              cmdCredit
);

  localparam int PtrBits   = $clog2(`HEAP_CMD_DEPTH);
  localparam int CountBits = PtrBits + 1;

  heapPkg::heapOp    opMem    [`HEAP_CMD_DEPTH];
  heapPkg::arrayId   arrayMem [`HEAP_CMD_DEPTH];
  heapPkg::elemIndex indexMem [`HEAP_CMD_DEPTH];
  heapPkg::dataWord  dataMem  [`HEAP_CMD_DEPTH];

  logic [PtrBits-1:0]   wrPtr;
  logic [PtrBits-1:0]   rdPtr;
  logic [CountBits-1:0] count;

  // Host credits guarantee room for every push
  always_ff @(posedge clock) begin
    if (cmdValid) begin
      opMem[wrPtr]    <= cmdOp;
      arrayMem[wrPtr] <= cmdArray;
      indexMem[wrPtr] <= cmdIndex;
      dataMem[wrPtr]  <= cmdData;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      count     <= '0;
      cmdCredit <= 1'b0;
    end else begin
      if (cmdValid) begin
        wrPtr <= wrPtr + 1'b1;                          // Wraps at depth
      end
      if (qPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      count     <= count + CountBits'(cmdValid) - CountBits'(qPop);
      cmdCredit <= qPop;                                // Credit one cycle after pop
    end
  end

  assign qValid = (count != '0);
  assign qOp    = opMem[rdPtr];
  assign qArray = arrayMem[rdPtr];
  assign qIndex = indexMem[rdPtr];
  assign qData  = dataMem[rdPtr];

endmodule

`default_nettype wire

/* heapAllocator.sv */
//--------------------------------------------------------------------
// Array allocator
// Stack of freed arrays, high-water counter and allocation bitmap
//--------------------------------------------------------------------
`default_nettype none

`include "heap_config.svh"

module heapAllocator (
  input  logic            clock,
  input  logic            resetN,
  input  logic            allocReq,
  input  logic            freeReq,
  input  logic            clearReq,
  input  heapPkg::arrayId reqArray,
  output heapPkg::arrayId grantArray,
  output logic            grantOk,
  output logic            isAllocated
);

  localparam int Arrays    = 1 << `HEAP_ARRAY_BITS;
  localparam int CountBits = `HEAP_ARRAY_BITS + 1;

  heapPkg::arrayId      freeStack [Arrays];
  logic [CountBits-1:0] stackTop;         // Entries on the free stack
  logic [CountBits-1:0] highWater;        // Arrays ever handed out
  logic [Arrays-1:0]    allocated;
  heapPkg::arrayId      topArray;

  assign topArray = freeStack[heapPkg::arrayId'(stackTop - 1'b1)];

  // Freed arrays first, then fresh ones
  assign grantArray  = (stackTop != '0) ? topArray : heapPkg::arrayId'(highWater);
  assign grantOk     = (stackTop != '0) || (highWater != CountBits'(Arrays));
  assign isAllocated = allocated[reqArray];

  always_ff @(posedge clock) begin
    if (freeReq) begin
      freeStack[heapPkg::arrayId'(stackTop)] <= reqArray;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      stackTop  <= '0;
      highWater <= '0;
      allocated <= '0;
    end else if (clearReq) begin
      stackTop  <= '0;                              // Heap reset
      highWater <= '0;
      allocated <= '0;
    end else if (allocReq && grantOk) begin
      allocated[grantArray] <= 1'b1;
      if (stackTop != '0) begin
        stackTop <= stackTop - 1'b1;                // Reuse last freed
      end else begin
        highWater <= highWater + 1'b1;
      end
    end else if (freeReq) begin
      allocated[reqArray] <= 1'b0;
      stackTop            <= stackTop + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* heapArrayStore.sv */
//--------------------------------------------------------------------
// Array store
// Element memory and per-array sizes, updated by validated operations
//--------------------------------------------------------------------
`default_nettype none

`include "heap_config.svh"

module heapArrayStore (
  input  logic              clock,
  input  logic              resetN,
  input  logic              writeEn,
  input  heapPkg::heapOp    storeOp,
  input  heapPkg::arrayId   storeArray,
  input  heapPkg::elemIndex storeIndex,
  input  heapPkg::dataWord  storeData,
  input  logic              clearSize,
  output heapPkg::arraySize curSize,
  output heapPkg::dataWord  curElem
);

  localparam int Arrays = 1 << `HEAP_ARRAY_BITS;
  localparam int Length = 1 << `HEAP_INDEX_BITS;

  heapPkg::dataWord  elems [Arrays][Length];
  heapPkg::arraySize sizes [Arrays];
  heapPkg::elemIndex elemAddr;
  heapPkg::arraySize writeSize;

  assign curSize = sizes[storeArray];

  // Push writes just past the end, pop reads the top
  always_comb begin
    case (storeOp)
      heapPkg::opPush: elemAddr = heapPkg::elemIndex'(curSize);
      heapPkg::opPop:  elemAddr = heapPkg::elemIndex'(curSize - 1'b1);
      default:         elemAddr = storeIndex;
    endcase
  end

  assign curElem   = elems[storeArray][elemAddr];
  assign writeSize = {1'b0, storeIndex} + 1'b1;

  always_ff @(posedge clock) begin
    if (writeEn) begin
      case (storeOp)
        heapPkg::opWrite, heapPkg::opPush: begin
          elems[storeArray][elemAddr] <= storeData;
        end
        heapPkg::opAdd: begin
          elems[storeArray][elemAddr] <= curElem + storeData;   // Wraps at data width
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < Arrays; i++) begin
        sizes[i] <= '0;
      end
    end else if (clearSize) begin
      sizes[storeArray] <= '0;                                  // Fresh allocation
    end else if (writeEn) begin
      case (storeOp)
        heapPkg::opWrite: begin
          if (writeSize > curSize) begin
            sizes[storeArray] <= writeSize;
          end
        end
        heapPkg::opPush: sizes[storeArray] <= curSize + 1'b1;
        heapPkg::opPop:  sizes[storeArray] <= curSize - 1'b1;
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* heapController.sv */
//--------------------------------------------------------------------
// Heap controller
// Takes queued commands, checks them, dispatches the work and
// returns one response per command under response credit
//--------------------------------------------------------------------
`default_nettype none

`include "heap_config.svh"

module heapController (
  input  logic              clock,
  input  logic              resetN,
  input  logic              qValid,
  input  heapPkg::heapOp    qOp,
  input  heapPkg::arrayId   qArray,
  input  heapPkg::elemIndex qIndex,
  input  heapPkg::dataWord  qData,
  input  logic              rspCredit,
  output logic              qPop,
  output logic              allocReq,
  output logic              freeReq,
  output logic              clearReq,
  output heapPkg::arrayId   reqArray,
  input  heapPkg::arrayId   grantArray,
  input  logic              grantOk,
  input  logic              isAllocated,
  output logic              writeEn,
  output logic              clearSize,
  output heapPkg::heapOp    storeOp,
  output heapPkg::arrayId   storeArray,
  output heapPkg::elemIndex storeIndex,
  output heapPkg::dataWord  storeData,
  input  heapPkg::arraySize curSize,
  input  heapPkg::dataWord  curElem,
  output logic              rspValid,
  output heapPkg::dataWord  rspData,
  output heapPkg::heapError rspError
);

  localparam int CreditBits = $clog2(`HEAP_RSP_CREDITS + 1);
  localparam heapPkg::arraySize FullSize = heapPkg::arraySize'(1 << `HEAP_INDEX_BITS);

  heapPkg::ctrlState  state;
  heapPkg::heapOp     opReg;
  heapPkg::arrayId    arrayReg;
  heapPkg::elemIndex  indexReg;
  heapPkg::dataWord   dataReg;
  heapPkg::heapError  errReg;
  heapPkg::heapError  checkError;
  heapPkg::dataWord   result;
  logic               commit;
  logic [CreditBits-1:0] rspCredits;

  //------------------------------------------------------------------
  // Request decode
  //------------------------------------------------------------------
  always_comb begin
    qPop      = (state == heapPkg::stIdle) && qValid;
    commit    = (state == heapPkg::stExecute) && (errReg == heapPkg::errNone);
    allocReq  = commit && (opReg == heapPkg::opAlloc);
    freeReq   = commit && (opReg == heapPkg::opFree);
    clearReq  = commit && (opReg == heapPkg::opReset);
    clearSize = allocReq;                                   // New arrays start empty
    writeEn   = commit && (opReg inside {heapPkg::opWrite, heapPkg::opPush,
                                         heapPkg::opPop, heapPkg::opAdd});
    rspValid  = (state == heapPkg::stRespond) && (rspCredits != '0);
  end

  assign reqArray   = arrayReg;
  assign storeOp    = opReg;
  assign storeArray = (opReg == heapPkg::opAlloc) ? grantArray : arrayReg;
  assign storeIndex = indexReg;
  assign storeData  = dataReg;

  // Access checks
  always_comb begin
    checkError = heapPkg::errNone;
    case (opReg)
      heapPkg::opReset: checkError = heapPkg::errNone;
      heapPkg::opAlloc: begin
        if (!grantOk) checkError = heapPkg::errNoMemory;
      end
      default: begin
        if (!isAllocated) begin
          checkError = heapPkg::errNotAllocated;            // Also catches double free
        end else if ((opReg inside {heapPkg::opRead, heapPkg::opAdd}) &&
                     ({1'b0, indexReg} >= curSize)) begin
          checkError = heapPkg::errOutOfBounds;
        end else if (opReg == heapPkg::opPush && curSize == FullSize) begin
          checkError = heapPkg::errFull;
        end else if (opReg == heapPkg::opPop && curSize == '0) begin
          checkError = heapPkg::errEmpty;
        end
      end
    endcase
  end

  always_comb begin
    case (opReg)
      heapPkg::opAlloc:               result = heapPkg::dataWord'(grantArray);
      heapPkg::opWrite:               result = dataReg;
      heapPkg::opRead, heapPkg::opPop: result = curElem;      // Pop sees the top element
      heapPkg::opSize:                result = heapPkg::dataWord'(curSize);
      heapPkg::opAdd:                 result = curElem + dataReg;
      default:                        result = '0;
    endcase
  end

  //------------------------------------------------------------------
  // Command registers and FSM
  //------------------------------------------------------------------
  always_ff @(posedge clock) begin
    if (qPop) begin
      opReg    <= qOp;
      arrayReg <= qArray;
      indexReg <= qIndex;
      dataReg  <= qData;
    end
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state      <= heapPkg::stIdle;
      errReg     <= heapPkg::errNone;
      rspData    <= '0;
      rspError   <= heapPkg::errNone;
      rspCredits <= CreditBits'(`HEAP_RSP_CREDITS);
    end else begin
      rspCredits <= rspCredits + CreditBits'(rspCredit) - CreditBits'(rspValid);
      case (state)
        heapPkg::stIdle: begin
          if (qValid) state <= heapPkg::stCheck;
        end
        heapPkg::stCheck: begin
          errReg <= checkError;
          state  <= heapPkg::stExecute;
        end
        heapPkg::stExecute: begin
          rspError <= errReg;
          rspData  <= (errReg == heapPkg::errNone) ? result : '0;   // Errors carry no data
          state    <= heapPkg::stRespond;
        end
        default: begin
          if (rspValid) state <= heapPkg::stIdle;          // Hold until a credit is free
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* heapTop.sv */
//--------------------------------------------------------------------
// Array heap unit
// Command queue, controller, allocator and element store
//--------------------------------------------------------------------
`default_nettype none

module heapTop (
  input  logic              clock,
  input  logic              resetN,
  input  logic              cmdValid,
  input  heapPkg::heapOp    cmdOp,
  input  heapPkg::arrayId   cmdArray,
  input  heapPkg::elemIndex cmdIndex,
  input  heapPkg::dataWord  cmdData,
  output logic              cmdCredit,
  output logic              rspValid,
  output heapPkg::dataWord  rspData,
  output heapPkg::heapError rspError,
  input  logic              rspCredit
);

  // Queue head
  logic              qValid;
  logic              qPop;
  heapPkg::heapOp    qOp;
  heapPkg::arrayId   qArray;
  heapPkg::elemIndex qIndex;
  heapPkg::dataWord  qData;

  // Allocator
  logic              allocReq;
  logic              freeReq;
  logic              clearReq;
  heapPkg::arrayId   reqArray;
  heapPkg::arrayId   grantArray;
  logic              grantOk;
  logic              isAllocated;

  // Store
  logic              writeEn;
  logic              clearSize;
  heapPkg::heapOp    storeOp;
  heapPkg::arrayId   storeArray;
  heapPkg::elemIndex storeIndex;
  heapPkg::dataWord  storeData;
  heapPkg::arraySize curSize;
  heapPkg::dataWord  curElem;

  heapCommandQueue queue (
    .clock, .resetN, .cmdValid, .cmdOp, .cmdArray, .cmdIndex, .cmdData,
    .qPop, .qValid, .qOp, .qArray, .qIndex, .qData, .cmdCredit
  );

  heapController ctrl (
    .clock, .resetN, .qValid, .qOp, .qArray, .qIndex, .qData, .rspCredit,
    .qPop, .allocReq, .freeReq, .clearReq, .reqArray, .grantArray, .grantOk,
    .isAllocated, .writeEn, .clearSize, .storeOp, .storeArray, .storeIndex,
    .storeData, .curSize, .curElem, .rspValid, .rspData, .rspError
  );

  heapAllocator alloc (
    .clock, .resetN, .allocReq, .freeReq, .clearReq, .reqArray,
    .grantArray, .grantOk, .isAllocated
  );

  heapArrayStore store (
    .clock, .resetN, .writeEn, .storeOp, .storeArray, .storeIndex,
    .storeData, .clearSize, .curSize, .curElem
  );

endmodule

`default_nettype wire

/* heapChecker.sv */
//--------------------------------------------------------------------
// Response checker
// Heap reference model, in-order response compare and credit counters
//--------------------------------------------------------------------
`default_nettype none

`include "heap_config.svh"

module heapChecker (
  input  logic              clock,
  input  logic              resetN,
  input  logic              cmdValid,
  input  heapPkg::heapOp    cmdOp,
  input  heapPkg::arrayId   cmdArray,
  input  heapPkg::elemIndex cmdIndex,
  input  heapPkg::dataWord  cmdData,
  input  logic              cmdCredit,
  input  logic              rspValid,
  input  heapPkg::dataWord  rspData,
  input  heapPkg::heapError rspError,
  input  logic              rspCredit,
  input  logic              drained,
  output int                respCount,
  output int                dataErrors,
  output int                flowErrors
);

  localparam int Arrays = 1 << `HEAP_ARRAY_BITS;
  localparam int Length = 1 << `HEAP_INDEX_BITS;

  bit                allocated [Arrays];
  int                sizes     [Arrays];
  heapPkg::dataWord  elems     [Arrays][Length];
  bit                known     [Arrays][Length];    // Element written at least once
  heapPkg::arrayId   freeStack [$];
  int                highWater;
  heapPkg::dataWord  expData   [$];
  heapPkg::heapError expErr    [$];
  bit                expKnown  [$];
  int                accepted;
  int                cmdCredits;
  int                rspCreditsGiven;
  bit                finalDone;

  //------------------------------------------------------------------
  // Reference model applied once per accepted command
  //------------------------------------------------------------------
  task automatic applyCommand(input heapPkg::heapOp op, input heapPkg::arrayId a,
                              input heapPkg::elemIndex i, input heapPkg::dataWord d);
    heapPkg::heapError err;
    heapPkg::dataWord  rsp;
    bit                isKnown;
    err     = heapPkg::errNone;
    rsp     = '0;
    isKnown = 1'b1;
    if (op == heapPkg::opReset) begin
      foreach (allocated[k]) allocated[k] = 1'b0;
      freeStack.delete();
      highWater = 0;
    end else if (op == heapPkg::opAlloc) begin
      if (freeStack.size() == 0 && highWater == Arrays) begin
        err = heapPkg::errNoMemory;
      end else begin
        if (freeStack.size() != 0) begin
          a = freeStack.pop_back();                   // Last freed comes back first
        end else begin
          a = heapPkg::arrayId'(highWater);
          highWater++;
        end
        allocated[a] = 1'b1;
        sizes[a]     = 0;
        rsp          = heapPkg::dataWord'(a);
      end
    end else if (!allocated[a]) begin
      err = heapPkg::errNotAllocated;
    end else begin
      case (op)
        heapPkg::opFree: begin
          allocated[a] = 1'b0;
          freeStack.push_back(a);
        end
        heapPkg::opWrite: begin
          elems[a][i] = d;
          known[a][i] = 1'b1;
          if (int'(i) >= sizes[a]) sizes[a] = int'(i) + 1;
          rsp = d;
        end
        heapPkg::opRead, heapPkg::opAdd: begin
          if (int'(i) >= sizes[a]) begin
            err = heapPkg::errOutOfBounds;
          end else begin
            if (op == heapPkg::opAdd) elems[a][i] = elems[a][i] + d;   // Wraps at 12 bits
            rsp     = elems[a][i];
            isKnown = known[a][i];
          end
        end
        heapPkg::opSize: rsp = heapPkg::dataWord'(sizes[a]);
        heapPkg::opPush: begin
          if (sizes[a] == Length) begin
            err = heapPkg::errFull;
          end else begin
            elems[a][heapPkg::elemIndex'(sizes[a])] = d;
            known[a][heapPkg::elemIndex'(sizes[a])] = 1'b1;
            sizes[a]++;
          end
        end
        heapPkg::opPop: begin
          if (sizes[a] == 0) begin
            err = heapPkg::errEmpty;
          end else begin
            sizes[a]--;
            rsp     = elems[a][heapPkg::elemIndex'(sizes[a])];
            isKnown = known[a][heapPkg::elemIndex'(sizes[a])];
          end
        end
        default: begin
        end
      endcase
    end
    expData.push_back(rsp);
    expErr.push_back(err);
    expKnown.push_back(isKnown);
  endtask

  task automatic compareResponse();
    respCount++;
    if (respCount > `HEAP_RSP_CREDITS + rspCreditsGiven) begin
      flowErrors++;
      $display("Response %0d was sent without a response credit", respCount);
    end
    if (expErr.size() == 0) begin
      flowErrors++;
      $display("Response %0d arrived with no command pending", respCount);
    end else begin
      if (rspError != expErr[0]) begin
        dataErrors++;
        $display("[FAIL] rspError: expected 0x%0h, got 0x%0h (response %0d)",
                 expErr[0], rspError, respCount);
      end
      if (expKnown[0] && rspData != expData[0]) begin
        dataErrors++;
        $display("[FAIL] rspData: expected 0x%03h, got 0x%03h (response %0d)",
                 expData[0], rspData, respCount);
      end
      void'(expData.pop_front());
      void'(expErr.pop_front());
      void'(expKnown.pop_front());
    end
  endtask

  //------------------------------------------------------------------
  // Port sampling and closing counts
  //------------------------------------------------------------------
  always @(posedge clock) begin
    if (resetN) begin
      if (rspValid) compareResponse();          // Before this cycle's credit
      if (rspCredit) rspCreditsGiven++;
      if (cmdCredit) cmdCredits++;
      if (cmdValid) begin
        accepted++;
        applyCommand(cmdOp, cmdArray, cmdIndex, cmdData);
      end
    end
    if (drained && !finalDone) begin
      finalDone = 1'b1;
      if (respCount != accepted) begin
        flowErrors++;
        $display("Got %0d responses for %0d accepted commands", respCount, accepted);
      end
      if (cmdCredits != accepted) begin
        flowErrors++;
        $display("Got %0d command credits for %0d accepted commands", cmdCredits, accepted);
      end
    end
  end

endmodule

`default_nettype wire

/* heap_assert.sv */
//--------------------------------------------------------------------
// Port assertions on the heap unit top level
//--------------------------------------------------------------------
`default_nettype none

module heapAssert (
  input logic              clock,
  input logic              resetN,
  input logic              rspValid,
  input logic              cmdCredit,
  input heapPkg::dataWord  rspData,
  input heapPkg::heapError rspError
);

  quietInReset: assert property (@(posedge clock) !resetN |-> !rspValid && !cmdCredit)
    else $error("rspValid or cmdCredit high during reset");

  // Error responses carry no data
  errorNoData: assert property (@(posedge clock) disable iff (!resetN)
                                rspError != heapPkg::errNone |-> rspData == '0)
    else $error("rspData not zero with an error code");

endmodule

bind heapTop heapAssert portCheck (
  .clock(clock), .resetN(resetN), .rspValid(rspValid), .cmdCredit(cmdCredit),
  .rspData(rspData), .rspError(rspError)
);

`default_nettype wire

/* heapTb.sv */
//--------------------------------------------------------------------
// Heap unit testbench
// Seeded random commands under credit flow control, with watchdog
//--------------------------------------------------------------------
`default_nettype none

`include "heap_config.svh"

module heapTb;

  localparam int Commands = 400;
  localparam int Period   = 100;

  logic              clock;
  logic              resetN;
  logic              cmdValid;
  heapPkg::heapOp    cmdOp;
  heapPkg::arrayId   cmdArray;
  heapPkg::elemIndex cmdIndex;
  heapPkg::dataWord  cmdData;
  logic              cmdCredit;
  logic              rspValid;
  heapPkg::dataWord  rspData;
  heapPkg::heapError rspError;
  logic              rspCredit = 1'b0;
  logic              drained;
  int                respCount;
  int                dataErrors;
  int                flowErrors;
  int                sent;
  int                returned;                  // Command credits back from the DUT
  int                cycle;
  int                owed;                      // Response credits due now
  int                dueCycles [$];

  heapTop u_dut (
    .clock, .resetN, .cmdValid, .cmdOp, .cmdArray, .cmdIndex, .cmdData,
    .cmdCredit, .rspValid, .rspData, .rspError, .rspCredit
  );

  heapChecker respCheck (
    .clock, .resetN, .cmdValid, .cmdOp, .cmdArray, .cmdIndex, .cmdData,
    .cmdCredit, .rspValid, .rspData, .rspError, .rspCredit, .drained,
    .respCount, .dataErrors, .flowErrors
  );

  initial begin
    clock = 1'b0;
    forever #(Period / 2) clock = ~clock;
  end

  // Alloc and Free weighted so the heap runs out
  function automatic heapPkg::heapOp pickOp();
    int r;
    r = $urandom_range(99);
    if (r < 3) return heapPkg::opReset;
    else if (r < 28) return heapPkg::opAlloc;
    else if (r < 42) return heapPkg::opFree;
    else if (r < 56) return heapPkg::opWrite;
    else if (r < 66) return heapPkg::opRead;
    else if (r < 72) return heapPkg::opSize;
    else if (r < 82) return heapPkg::opPush;
    else if (r < 90) return heapPkg::opPop;
    else return heapPkg::opAdd;
  endfunction

  always @(posedge clock) begin
    cycle++;
    if (cmdCredit) returned++;
    if (resetN && rspValid) dueCycles.push_back(cycle + $urandom_range(3));
  end

  // Response credits go back after 0 to 3 cycles
  always @(negedge clock) begin
    for (int i = dueCycles.size() - 1; i >= 0; i--) begin
      if (dueCycles[i] <= cycle) begin
        owed++;
        dueCycles.delete(i);
      end
    end
    rspCredit = (owed > 0);
    if (owed > 0) owed--;
  end

  initial begin
    void'($urandom(32'h291e));
    resetN   = 1'b0;
    cmdValid = 1'b0;
    cmdOp    = heapPkg::opReset;
    cmdArray = '0;
    cmdIndex = '0;
    cmdData  = '0;
    drained  = 1'b0;
    repeat (3) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;
    while (sent < Commands) begin
      @(negedge clock);
      cmdValid = 1'b0;
      if (sent - returned < `HEAP_CMD_DEPTH && $urandom_range(3) != 0) begin
        cmdValid = 1'b1;
        cmdOp    = pickOp();
        cmdArray = heapPkg::arrayId'($urandom());     // Unallocated ones too
        cmdIndex = heapPkg::elemIndex'($urandom());
        cmdData  = heapPkg::dataWord'($urandom());
        sent++;
      end
    end
    @(negedge clock);
    cmdValid = 1'b0;
    wait (respCount == Commands);
    repeat (8) @(negedge clock);
    drained = 1'b1;
    @(negedge clock);
    $display("Errors: %0d data, %0d flow", dataErrors, flowErrors);
    if (dataErrors == 0 && flowErrors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Watchdog allows 20 cycles per command
  initial begin
    #(Commands * 20 * Period);
    $display("Timeout with %0d of %0d responses received", respCount, Commands);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
heapPkg.sv
heapCommandQueue.sv
heapAllocator.sv
heapArrayStore.sv
heapController.sv
heapTop.sv
heapChecker.sv
heap_assert.sv
heapTb.sv

/* Makefile */
# Verilator build and run of the heap unit testbench

SOURCES := $(filter %.sv,$(shell cat verilog.f)) heap_config.svh

.PHONY: all run clean

all: run

obj_dir/VheapTb: verilog.f $(SOURCES)
	verilator --binary --assert -f verilog.f --top-module heapTb -o VheapTb

run: obj_dir/VheapTb
	@out="$$(./obj_dir/VheapTb)"; echo "$$out"; echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir
